// File: Makefile
TOP = bp_frontend_tb

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "tests failed" >> sim.log
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: testbench/bp_frontend_assert.sv
// Front end protocol assertions
`timescale 1ns/100ps

module bp_frontend_assert (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input bp_pkg::resolve_t    resolve,
    input bp_pkg::fetch_t      fetch,
    input bp_pkg::btb_update_t update,
    input bp_pkg::redirect_t   redirect
);

    // No bundle leaves while reset is held.
    valid_in_reset: assert property (@(posedge clk) rst |=> !fetch.valid)
        else $error("fetch.valid set while in reset");

    // Stall freezes the fetch address unless redirected.
    pc_holds_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && !redirect.valid) |=> $stable(fetch.pc))
        else $error("fetch.pc moved under stall");

    // Every BTB write traces back to a resolve.
    update_needs_resolve: assert property (@(posedge clk) disable iff (rst)
        update.we |-> $past(resolve.valid))
        else $error("BTB update without a resolve in the previous cycle");

endmodule

bind bp_frontend bp_frontend_assert i_assert (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .resolve  (resolve),
    .fetch    (fetch),
    .update   (update),
    .redirect (redirect)
);

// File: testbench/bp_frontend_tb.sv
// Branch prediction front end testbench
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_frontend_tb;

    localparam logic [31:0] SEED = 32'h875e_f0b8;
    localparam int RESET_WAIT = 20;

    logic             clk;
    logic             rst;
    logic             stall;
    bp_pkg::resolve_t resolve;
    bp_pkg::fetch_t   fetch;

    // Stimulus table with one entry per cycle.
    logic             row_stall[$];
    bp_pkg::resolve_t row_resolve[$];
    bp_pkg::fetch_t   row_expect[$];
    logic             row_redirect[$];

    // Targets carried by branches that resolve not taken.
    logic [31:0] untaken_a;
    logic [31:0] untaken_b;

    bp_frontend i_dut (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .resolve (resolve),
        .fetch   (fetch)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp, input string where);
        fail_now($sformatf("[ERROR] %s got %h expected %h at %s", name, got, exp, where));
    endtask

    // Target fields only mean something on a hit.
    task automatic check_fetch(input bp_pkg::fetch_t got, input bp_pkg::fetch_t exp,
                               input string where);
        if (got.valid !== exp.valid) begin
            report_value("fetch.valid", got.valid, exp.valid, where);
        end
        if (got.pc !== exp.pc) begin
            report_value("fetch.pc", got.pc, exp.pc, where);
        end
        if (got.hit !== exp.hit) begin
            report_value("fetch.hit", got.hit, exp.hit, where);
        end
        if (exp.hit) begin
            if (got.pred_taken !== exp.pred_taken) begin
                report_value("fetch.pred_taken", got.pred_taken, exp.pred_taken, where);
            end
            if (got.pred_target !== exp.pred_target) begin
                report_value("fetch.pred_target", got.pred_target, exp.pred_target, where);
            end
        end
    endtask

    task automatic check_redirect_pc(input logic [31:0] got, input logic [31:0] exp,
                                     input string where);
        if (got !== exp) begin
            report_value("fetch.pc after redirect", got, exp, where);
        end
    endtask

    function automatic bp_pkg::resolve_t resolved_branch(input logic [31:0] pc,
        input logic taken, input logic [31:0] target, input logic pred_taken,
        input logic [31:0] pred_target);
        bp_pkg::resolve_t r;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.taken       = taken;
        r.target      = target;
        r.pred_taken  = pred_taken;
        r.pred_target = pred_target;
        return r;
    endfunction

    // Where a wrong prediction sends fetch.
    function automatic logic [31:0] correct_path(input bp_pkg::resolve_t r);
        if (r.taken) begin
            return r.target;
        end
        return r.pc + 32'd4;
    endfunction

    function automatic logic [`BP_INDEX_WIDTH-1:0] index_of(input logic [31:0] pc);
        return pc[`BP_INDEX_WIDTH+2:3];
    endfunction

    function automatic logic [`BP_TAG_WIDTH-1:0] tag_of(input logic [31:0] pc);
        return pc[`BP_INDEX_WIDTH+`BP_TAG_WIDTH+2:`BP_INDEX_WIDTH+3];
    endfunction

    task automatic add_row(input logic st, input bp_pkg::resolve_t rs, input logic [31:0] pc,
                           input logic hit, input logic [1:0] pred, input logic [31:0] target,
                           input logic redir);
        bp_pkg::fetch_t exp;
        exp.valid       = 1'b1;
        exp.pc          = pc;
        exp.pred_taken  = pred;
        exp.pred_target = target;
        exp.hit         = hit;
        row_stall.push_back(st);
        row_resolve.push_back(rs);
        row_expect.push_back(exp);
        row_redirect.push_back(redir);
    endtask

    // Each row gives the fetch bundle of the following cycle.
    task automatic build_table();
        bp_pkg::resolve_t none;
        none = '0;
        add_row(0, none, 32'h1018, 0, 2'b00, 32'h0, 0);
        add_row(0, none, 32'h1020, 0, 2'b00, 32'h0, 0);
        // Loop branch in slot 1 first seen as not taken.
        add_row(0, resolved_branch(32'h1034, 1, 32'h1010, 0, 32'h0), 32'h1028, 0, 2'b00, 0, 0);
        add_row(0, none, 32'h1010, 0, 2'b00, 32'h0, 1);
        add_row(0, none, 32'h1018, 0, 2'b00, 32'h0, 0);
        add_row(0, none, 32'h1020, 0, 2'b00, 32'h0, 0);
        add_row(0, none, 32'h1028, 0, 2'b00, 32'h0, 0);
        add_row(0, none, 32'h1030, 1, 2'b10, 32'h1010, 0);
        add_row(0, none, 32'h1010, 0, 2'b00, 32'h0, 0);
        // Slot 0 branch and then a jump into the upper slot of its bundle.
        add_row(0, resolved_branch(32'h1048, 1, 32'h1060, 0, 32'h0), 32'h1018, 0, 2'b00, 0, 0);
        add_row(0, none, 32'h1060, 0, 2'b00, 32'h0, 1);
        add_row(0, resolved_branch(32'h1200, 1, 32'h104c, 0, 32'h0), 32'h1068, 0, 2'b00, 0, 0);
        add_row(0, none, 32'h104c, 1, 2'b00, 32'h1060, 1);
        add_row(0, none, 32'h1050, 0, 2'b00, 32'h0, 0);
        // Stall with a mispredict arriving in the middle.
        add_row(1, none, 32'h1050, 0, 2'b00, 32'h0, 0);
        add_row(1, none, 32'h1050, 0, 2'b00, 32'h0, 0);
        add_row(1, resolved_branch(32'h1100, 0, untaken_a, 1, 32'h1010), 32'h1050, 0, 0, 0, 0);
        add_row(1, none, 32'h1104, 1, 2'b00, untaken_a, 1);
        add_row(1, none, 32'h1104, 1, 2'b00, untaken_a, 0);
        add_row(0, none, 32'h1108, 0, 2'b00, 32'h0, 0);
        // Same index as the loop branch with another tag.
        add_row(0, resolved_branch(32'h1300, 1, 32'h1230, 0, 32'h0), 32'h1110, 0, 2'b00, 0, 0);
        add_row(0, none, 32'h1230, 0, 2'b00, 32'h0, 1);
        add_row(0, none, 32'h1238, 0, 2'b00, 32'h0, 0);
        // Loop branch falls through and loses its taken bit.
        add_row(0, resolved_branch(32'h1034, 0, untaken_b, 1, 32'h1010), 32'h1240, 0, 0, 0, 0);
        add_row(0, none, 32'h1038, 0, 2'b00, 32'h0, 1);
        add_row(0, none, 32'h1040, 0, 2'b00, 32'h0, 0);
        add_row(0, resolved_branch(32'h1400, 1, 32'h1030, 0, 32'h0), 32'h1048, 1, 2'b01,
                32'h1060, 0);
        add_row(0, none, 32'h1030, 1, 2'b00, untaken_b, 1);
        add_row(0, none, 32'h1038, 0, 2'b00, 32'h0, 0);
        // Correct prediction leaves the flow alone.
        add_row(0, resolved_branch(32'h1048, 1, 32'h1060, 1, 32'h1060), 32'h1040, 0, 0, 0, 0);
        add_row(0, none, 32'h1048, 1, 2'b01, 32'h1060, 0);
        add_row(0, none, 32'h1060, 0, 2'b00, 32'h0, 0);
        add_row(0, none, 32'h1068, 0, 2'b00, 32'h0, 0);
        // Right direction but a stale target.
        add_row(0, resolved_branch(32'h1048, 1, 32'h1080, 1, 32'h1060), 32'h1070, 0, 0, 0, 0);
        add_row(0, none, 32'h1080, 0, 2'b00, 32'h0, 1);
    endtask

    initial begin
        bp_pkg::fetch_t expected;
        int             wait_cycles;
        clk     = 1'b0;
        rst     = 1'b1;
        stall   = 1'b0;
        resolve = '0;
        untaken_a = $urandom(SEED);
        untaken_b = $urandom();
        build_table();

        if (index_of(32'h1230) != index_of(32'h1034) || tag_of(32'h1230) == tag_of(32'h1034)) begin
            fail_now("Aliasing addresses in the table do not map to one index with two tags");
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expected    = '0;
        expected.pc = `BP_RESET_PC;
        check_fetch(fetch, expected, "first cycle after reset");

        wait_cycles = 0;
        while (!fetch.valid) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_WAIT) begin
                fail_now("fetch.valid did not rise after reset");
            end
        end
        expected.valid = 1'b1;
        expected.pc    = `BP_RESET_PC + 32'd8;
        check_fetch(fetch, expected, "first valid bundle");

        for (int i = 0; i <= row_stall.size(); i++) begin
            @(posedge clk);
            if (i < row_stall.size()) begin
                stall   <= row_stall[i];
                resolve <= row_resolve[i];
            end else begin
                stall   <= 1'b0;
                resolve <= '0;
            end
            @(negedge clk);
            if (i > 0) begin
                if (row_redirect[i-1]) begin
                    check_redirect_pc(fetch.pc, correct_path(row_resolve[i-2]),
                                      $sformatf("row %0d", i - 1));
                end
                check_fetch(fetch, row_expect[i-1], $sformatf("row %0d", i - 1));
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/bp_config.svh
// Branch predictor sizing
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Index bits of the BTB, 64 entries.
`define BP_INDEX_WIDTH 6

// Tag bits kept per entry.
`define BP_TAG_WIDTH 6

// First fetch address after reset.
`define BP_RESET_PC 32'h0000_1000

`endif

// File: verilog/bp_frontend.sv
// Branch prediction front end
`timescale 1ns/100ps

module bp_frontend (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  bp_pkg::resolve_t resolve,
    output bp_pkg::fetch_t   fetch
);

    logic [31:0]         lookup_pc;
    logic [1:0]          pred_taken;
    logic [31:0]         pred_target;
    logic                hit;
    bp_pkg::btb_update_t update;
    bp_pkg::redirect_t   redirect;

    fetch_ctrl i_fetch_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .lookup_pc   (lookup_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .hit         (hit),
        .fetch       (fetch)
    );

    btb i_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc   (lookup_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .hit         (hit),
        .update      (update)
    );

    // Execute feedback.
    branch_check i_branch_check (
        .clk      (clk),
        .rst      (rst),
        .resolve  (resolve),
        .update   (update),
        .redirect (redirect)
    );

endmodule

// File: verilog/bp_pkg.sv
// Branch predictor shared types

package bp_pkg;

    // One fetch bundle of two slots.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [1:0]  pred_taken;
        logic [31:0] pred_target;
        logic        hit;
    } fetch_t;

    // Branch outcome from execute, with the prediction it carried.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        pred_taken;
        logic [31:0] pred_target;
    } resolve_t;

    // BTB write request.
    typedef struct packed {
        logic        we;
        logic [31:0] pc;
        logic [1:0]  taken_slots;
        logic [31:0] target;
    } btb_update_t;

    // Fetch redirect after a mispredict.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

// File: verilog/branch_check.sv
// Branch mispredict check
`timescale 1ns/100ps

module branch_check (
    input  logic                clk,
    input  logic                rst,
    input  bp_pkg::resolve_t    resolve,
    output bp_pkg::btb_update_t update,
    output bp_pkg::redirect_t   redirect
);

    logic        dir_fail;
    logic        target_fail;
    logic        mispredict;
    logic [1:0]  slot_bits;
    logic [31:0] correct_pc;

    always_comb begin
        dir_fail    = resolve.taken != resolve.pred_taken;
        target_fail = resolve.taken && resolve.pred_taken &&
                      (resolve.target != resolve.pred_target);
        mispredict  = resolve.valid && (dir_fail || target_fail);

        // One-hot on the slot, empty when not taken.
        if (!resolve.taken) begin
            slot_bits = 2'b00;
        end else if (resolve.pc[2]) begin
            slot_bits = 2'b10;
        end else begin
            slot_bits = 2'b01;
        end

        // Fall through to the next slot.
        if (resolve.taken) begin
            correct_pc = resolve.target;
        end else begin
            correct_pc = resolve.pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        update.pc          <= resolve.pc;
        update.taken_slots <= slot_bits;
        update.target      <= resolve.target;
        redirect.pc        <= correct_pc;
        if (rst) begin
            update.we      <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            update.we      <= mispredict;
            redirect.valid <= mispredict;
        end
    end

endmodule

// File: verilog/btb.sv
// Direct-mapped branch target buffer
`timescale 1ns/100ps
`include "bp_config.svh"

module btb (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         lookup_pc,
    output logic [1:0]          pred_taken,
    output logic [31:0]         pred_target,
    output logic                hit,
    input  bp_pkg::btb_update_t update
);

    localparam int INDEX_W = `BP_INDEX_WIDTH;
    localparam int TAG_W   = `BP_TAG_WIDTH;
    localparam int ENTRIES = 1 << INDEX_W;

    // Bits 2..0 pick the byte in the bundle, index sits above them.
    localparam int INDEX_LO = 3;
    localparam int TAG_LO   = INDEX_LO + INDEX_W;

    logic [1:0]       taken_mem  [ENTRIES];
    logic [31:0]      target_mem [ENTRIES];
    logic [TAG_W-1:0] tag_mem    [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   rd_tag;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic [1:0]         entry_taken;

    assign rd_index = lookup_pc[TAG_LO-1:INDEX_LO];
    assign rd_tag   = lookup_pc[TAG_LO+TAG_W-1:TAG_LO];
    assign wr_index = update.pc[TAG_LO-1:INDEX_LO];
    assign wr_tag   = update.pc[TAG_LO+TAG_W-1:TAG_LO];

    // Lookup.
    always_comb begin
        entry_taken = taken_mem[rd_index];
        pred_target = target_mem[rd_index];
        hit         = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
        // Slot 0 lies behind a fetch that enters at the upper slot.
        if (lookup_pc[2]) begin
            pred_taken = {entry_taken[1], 1'b0};
        end else begin
            pred_taken = entry_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.we) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // Table contents.
    always_ff @(posedge clk) begin
        if (update.we) begin
            taken_mem[wr_index]  <= update.taken_slots;
            target_mem[wr_index] <= update.target;
            tag_mem[wr_index]    <= wr_tag;
        end
    end

endmodule

// File: verilog/fetch_ctrl.sv
// Fetch address control
`timescale 1ns/100ps
`include "bp_config.svh"

module fetch_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  bp_pkg::redirect_t redirect,
    output logic [31:0]       lookup_pc,
    input  logic [1:0]        pred_taken,
    input  logic [31:0]       pred_target,
    input  logic              hit,
    output bp_pkg::fetch_t    fetch
);

    logic [31:0] pc_q;
    logic        valid_q;
    logic [31:0] seq_pc;
    logic        take_pred;
    logic [31:0] next_pc;

    assign lookup_pc = pc_q;

    // Next bundle, aligned down to 8 bytes.
    assign seq_pc    = {pc_q[31:3], 3'b000} + 32'd8;
    assign take_pred = hit && (|pred_taken);

    // Redirect, stall, prediction, sequential.
    always_comb begin
        if (redirect.valid) begin
            next_pc = redirect.pc;
        end else if (stall) begin
            next_pc = pc_q;
        end else if (take_pred) begin
            next_pc = pred_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `BP_RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= next_pc;
            valid_q <= 1'b1;
        end
    end

    always_comb begin
        fetch.valid       = valid_q;
        fetch.pc          = pc_q;
        fetch.pred_taken  = pred_taken;
        fetch.pred_target = pred_target;
        fetch.hit         = hit;
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/btb.sv
verilog/branch_check.sv
verilog/fetch_ctrl.sv
verilog/bp_frontend.sv
testbench/bp_frontend_assert.sv
testbench/bp_frontend_tb.sv
